// ==== hdl/isaPkg.sv ====
package isaPkg;

   // Instruction word and field widths
   localparam int instWidth    = 32;
   localparam int regAddrWidth = 5;
   localparam int opcWidth     = 6;
   localparam int immWidth     = 16;

   // Low bit of each register field
   // Opcode sits on top, then rd, ra and rb
   localparam int rdLsb = instWidth - opcWidth - regAddrWidth;
   localparam int raLsb = rdLsb - regAddrWidth;
   localparam int rbLsb = raLsb - regAddrWidth;

   // IMM prefix carries the high half of the next immediate
   localparam logic [opcWidth-1:0] opcImm = 6'o54;

   // Return from subroutine
   localparam logic [opcWidth-1:0] opcRtd = 6'o55;

   // Unconditional branch, register and immediate forms
   localparam logic [opcWidth-1:0] opcBru  = 6'o46;
   localparam logic [opcWidth-1:0] opcBruI = 6'o56;

   // Conditional branch, register and immediate forms
   localparam logic [opcWidth-1:0] opcBcc  = 6'o47;
   localparam logic [opcWidth-1:0] opcBccI = 6'o57;

   // Pieces of the interrupt trap word
   // Link register for the return address
   localparam logic [regAddrWidth-1:0] intLinkReg = 5'd14;
   // Ra field selects absolute branch with link
   localparam logic [regAddrWidth-1:0] intBrMode = 5'h0c;
   // Interrupt vector
   localparam logic [immWidth-1:0] intVector = 16'h0010;

   // Branch-and-link immediate to the vector, saving into r14
   localparam logic [instWidth-1:0] intOp = {opcBruI, intLinkReg, intBrMode, intVector};

endpackage

// ==== hdl/busPkg.sv ====
package busPkg;

   // Instruction bus address width
   localparam int adrWidth = 32;

   // Instruction bus data width
   localparam int datWidth = 32;

   // Fetch starts here after reset
   localparam logic [adrWidth-1:0] resetPc = '0;

   // One word per fetch, byte addressed
   localparam logic [adrWidth-1:0] pcStep = 32'd4;

endpackage

// ==== hdl/fetchUnit.sv ====
module fetchUnit
   import isaPkg::*;
   import busPkg::*;
(
   input  logic                gclk,
   input  logic                grst,
   input  logic                hold,
   output logic                wbCyc,
   output logic                wbStb,
   output logic [adrWidth-1:0] wbAdr,
   input  logic                wbAck,
   input  logic [datWidth-1:0] wbDatI,
   output logic [instWidth-1:0] instData,
   output logic                dEn
);

   // Idle is also the one-cycle gap between transfers
   typedef enum logic {
      idle,
      request
   } fetchState;

   fetchState state;
   logic [adrWidth-1:0] pc;
   logic wordTaken;

   // Read-only master, no write enable or select lines
   // Cycle and strobe move together in classic mode
   assign wbCyc = (state == request);
   assign wbStb = (state == request);
   assign wbAdr = pc;

   // Transfer ends on the ack cycle
   assign wordTaken = wbCyc & wbStb & wbAck;

   // Stage advance strobe for the whole front end
   assign dEn = wordTaken;

   // Word goes straight to the buffer in the ack cycle
   assign instData = wbDatI;

   always_ff @(posedge gclk) begin
      if (grst) begin
         state <= idle;
         pc    <= resetPc;
      end else begin
         case (state)
            idle: begin
               // Back-pressure only blocks a new start
               if (!hold) begin
                  state <= request;
               end
            end
            request: begin
               if (wordTaken) begin
                  state <= idle;
                  // Strictly sequential
                  pc <= pc + pcStep;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // Master keeps the request and address until the slave acks
   property pAdrStable;
      @(posedge gclk) disable iff (grst)
         (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr));
   endproperty

   aAdrStable: assert property (pAdrStable)
      else $error("wbAdr or wbStb changed before wbAck");

endmodule

// ==== hdl/instBuffer.sv ====
module instBuffer
   import isaPkg::*;
(
   input  logic                    gclk,
   input  logic                    grst,
   input  logic                    dEn,
   input  logic [instWidth-1:0]    instData,
   input  logic                    msrIe,
   input  logic                    intReq,
   output logic [regAddrWidth-1:0] regfRa,
   output logic [regAddrWidth-1:0] regfRb,
   output logic [regAddrWidth-1:0] regfRd,
   output logic [instWidth-1:0]    instWord,
   output logic [opcWidth-1:0]     opcode,
   output logic [regAddrWidth-1:0] rd,
   output logic [regAddrWidth-1:0] ra,
   output logic [regAddrWidth-1:0] rb,
   output logic [immWidth-1:0]     imm,
   output logic [instWidth-1:0]    simm,
   output logic                    issueValid
);

   logic [1:0] intSync;
   logic intPrev;
   logic intShot;
   logic intLatch;
   logic prevImm;
   logic prevRtd;
   logic prevBru;
   logic prevBcc;
   logic injectOk;
   logic injectNow;
   logic [instWidth-1:0] nextWord;
   logic [instWidth-1:0] nextSimm;

   // Two-stage sampler of the async request, only while enabled
   // Shot fires once per request after two high samples
   assign intShot = intSync[1] & intSync[0] & ~intPrev;

   always_ff @(posedge gclk) begin
      if (grst) begin
         intSync  <= '0;
         intPrev  <= 1'b0;
         intLatch <= 1'b0;
      end else begin
         intSync <= msrIe ? {intSync[0], intReq} : 2'b00;
         intPrev <= intSync[1] & intSync[0];
         // Cleared by the issue of the trap word
         if (injectNow) begin
            intLatch <= 1'b0;
         end else begin
            intLatch <= (intLatch | intShot) & msrIe;
         end
      end
   end

   // Last issued opcode needs its following word untouched
   assign prevImm = (opcode == opcImm);
   assign prevRtd = (opcode == opcRtd);
   assign prevBru = (opcode == opcBru) | (opcode == opcBruI);
   assign prevBcc = (opcode == opcBcc) | (opcode == opcBccI);
   assign injectOk = ~(prevImm | prevRtd | prevBru | prevBcc);
   assign injectNow = dEn & intLatch & injectOk;

   // Trap word takes the slot of the fetched word
   assign nextWord = (intLatch && injectOk) ? intOp : instData;

   // Sign extension, or prefix high half over the new low half
   assign nextSimm = prevImm ?
      {imm, nextWord[immWidth-1:0]} :
      {{(instWidth - immWidth){nextWord[immWidth-1]}}, nextWord[immWidth-1:0]};

   // Register file addresses from the word being accepted
   assign regfRd = nextWord[rdLsb +: regAddrWidth];
   assign regfRa = nextWord[raLsb +: regAddrWidth];
   assign regfRb = nextWord[rbLsb +: regAddrWidth];

   // rb is the top of the immediate field
   assign rb = imm[immWidth-1 -: regAddrWidth];

   always_ff @(posedge gclk) begin
      if (grst) begin
         instWord   <= '0;
         opcode     <= '0;
         rd         <= '0;
         ra         <= '0;
         imm        <= '0;
         simm       <= '0;
         issueValid <= 1'b0;
      end else begin
         // One cycle after each accepted word
         issueValid <= dEn;
         if (dEn) begin
            instWord <= nextWord;
            opcode   <= nextWord[instWidth-1 -: opcWidth];
            rd       <= nextWord[rdLsb +: regAddrWidth];
            ra       <= nextWord[raLsb +: regAddrWidth];
            imm      <= nextWord[immWidth-1:0];
            simm     <= nextSimm;
         end
      end
   end

   // Pending interrupt is consumed by the first allowed slot
   // That slot carries the trap word out
   aLatchConsumed: assert property (@(posedge gclk) disable iff (grst)
      (dEn && intLatch && injectOk) |=> (!intLatch && instWord == intOp))
      else $error("injection slot kept the latch or issued no trap word");

endmodule

// ==== hdl/operandFetch.sv ====
module operandFetch
   import isaPkg::*;
(
   input  logic                    gclk,
   input  logic                    grst,
   input  logic                    dEn,
   input  logic [regAddrWidth-1:0] regfRa,
   input  logic [regAddrWidth-1:0] regfRb,
   input  logic [regAddrWidth-1:0] regfRd,
   input  logic                    wrEn,
   input  logic [regAddrWidth-1:0] wrAddr,
   input  logic [instWidth-1:0]    wrData,
   output logic [instWidth-1:0]    opA,
   output logic [instWidth-1:0]    opB,
   output logic [instWidth-1:0]    opD
);

   localparam int regCount = 2 ** regAddrWidth;

   // Machine word is one instruction wide
   logic [instWidth-1:0] regFile [regCount];

   // r0 is hardwired to zero on every read port
   function automatic logic [instWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
      logic [instWidth-1:0] value;
      if (addr == '0) begin
         value = '0;
      end else begin
         value = regFile[addr];
      end
      return value;
   endfunction

   // Single write port from writeback
   // r0 never written
   always_ff @(posedge gclk) begin
      if (wrEn && (wrAddr != '0)) begin
         regFile[wrAddr] <= wrData;
      end
   end

   // Operands advance with the buffer outputs
   // Same-cycle write is not forwarded, old value is read
   always_ff @(posedge gclk) begin
      if (grst) begin
         opA <= '0;
         opB <= '0;
         opD <= '0;
      end else if (dEn) begin
         opA <= readReg(regfRa);
         opB <= readReg(regfRb);
         opD <= readReg(regfRd);
      end
   end

   // Write to index 0 is dropped
   aZeroKept: assert property (@(posedge gclk) disable iff (grst)
      (wrEn && wrAddr == '0) |=> (regFile[0] === $past(regFile[0])))
      else $error("write to r0 changed register 0");

endmodule

// ==== hdl/coreFrontEnd.sv ====
module coreFrontEnd
   import isaPkg::*;
   import busPkg::*;
(
   input  logic                    gclk,
   input  logic                    grst,
   input  logic                    hold,
   // Wishbone instruction bus
   output logic                    wbCyc,
   output logic                    wbStb,
   output logic [adrWidth-1:0]     wbAdr,
   input  logic                    wbAck,
   input  logic [datWidth-1:0]     wbDatI,
   // Interrupt
   input  logic                    msrIe,
   input  logic                    intReq,
   // Register file write port
   input  logic                    wrEn,
   input  logic [regAddrWidth-1:0] wrAddr,
   input  logic [instWidth-1:0]    wrData,
   // Issued instruction
   output logic [instWidth-1:0]    instWord,
   output logic [opcWidth-1:0]     opcode,
   output logic [regAddrWidth-1:0] rd,
   output logic [regAddrWidth-1:0] ra,
   output logic [regAddrWidth-1:0] rb,
   output logic [immWidth-1:0]     imm,
   output logic [instWidth-1:0]    simm,
   output logic                    issueValid,
   // Operands
   output logic [instWidth-1:0]    opA,
   output logic [instWidth-1:0]    opB,
   output logic [instWidth-1:0]    opD
);

   logic [instWidth-1:0] instData;
   logic dEn;
   logic [regAddrWidth-1:0] regfRa;
   logic [regAddrWidth-1:0] regfRb;
   logic [regAddrWidth-1:0] regfRd;

   // Fetch stage
   fetchUnit u_fetchUnit (
      .gclk     (gclk),
      .grst     (grst),
      .hold     (hold),
      .wbCyc    (wbCyc),
      .wbStb    (wbStb),
      .wbAdr    (wbAdr),
      .wbAck    (wbAck),
      .wbDatI   (wbDatI),
      .instData (instData),
      .dEn      (dEn)
   );

   // Buffer stage, interrupt injection and decode
   instBuffer u_instBuffer (
      .gclk       (gclk),
      .grst       (grst),
      .dEn        (dEn),
      .instData   (instData),
      .msrIe      (msrIe),
      .intReq     (intReq),
      .regfRa     (regfRa),
      .regfRb     (regfRb),
      .regfRd     (regfRd),
      .instWord   (instWord),
      .opcode     (opcode),
      .rd         (rd),
      .ra         (ra),
      .rb         (rb),
      .imm        (imm),
      .simm       (simm),
      .issueValid (issueValid)
   );

   // Operand stage
   operandFetch u_operandFetch (
      .gclk   (gclk),
      .grst   (grst),
      .dEn    (dEn),
      .regfRa (regfRa),
      .regfRb (regfRb),
      .regfRd (regfRd),
      .wrEn   (wrEn),
      .wrAddr (wrAddr),
      .wrData (wrData),
      .opA    (opA),
      .opB    (opB),
      .opD    (opD)
   );

endmodule

// ==== tests/clockGen.sv ====
module clockGen (
   output logic gclk,
   output logic grst
);

   timeunit 1ns;
   timeprecision 100ps;

   // 100 ns period
   localparam int halfPeriod = 50;
   localparam int resetCycles = 2;

   initial begin
      gclk = 1'b0;
      forever #halfPeriod gclk = ~gclk;
   end

   // Released a short delay after the edge, like every other input
   initial begin
      grst = 1'b1;
      repeat (resetCycles) @(posedge gclk);
      #10;
      grst = 1'b0;
   end

endmodule

// ==== tests/tbFrontEnd.sv ====
module tbFrontEnd
   import isaPkg::*;
   import busPkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // 5 tests, about 100 issues each, at most 6 cycles per issue, plus margin
   localparam int timeoutCycles = 5 * 100 * 6 + 1000;
   localparam int memWords = 1024;

   logic gclk;
   logic grst;
   logic hold;
   logic wbCyc;
   logic wbStb;
   logic [adrWidth-1:0] wbAdr;
   logic wbAck;
   logic [datWidth-1:0] wbDatI;
   logic msrIe;
   logic intReq;
   logic wrEn;
   logic [regAddrWidth-1:0] wrAddr;
   logic [instWidth-1:0] wrData;
   logic [instWidth-1:0] instWord;
   logic [opcWidth-1:0] opcode;
   logic [regAddrWidth-1:0] rd;
   logic [regAddrWidth-1:0] ra;
   logic [regAddrWidth-1:0] rb;
   logic [immWidth-1:0] imm;
   logic [instWidth-1:0] simm;
   logic issueValid;
   logic [instWidth-1:0] opA;
   logic [instWidth-1:0] opB;
   logic [instWidth-1:0] opD;

   // Memory model and scoreboard
   logic [datWidth-1:0] mem [memWords];
   logic [datWidth-1:0] wordQ [$];
   logic [adrWidth-1:0] adrQ [$];
   logic [instWidth-1:0] regModel [32];
   integer seed = 73876;
   int waitLeft;
   bit ackSeen;

   // Checker state
   logic [adrWidth-1:0] expAdr;
   logic [instWidth-1:0] prevWord;
   bit trapAllowed;
   bit regsKnown;
   int trapCount;
   int immPairs;
   int issueCount;
   int errors;
   int checks;
   int errStart;
   int testsFailed;
   int cycleCount;
   string curTest;

   clockGen u_clockGen (
      .gclk (gclk),
      .grst (grst)
   );

   coreFrontEnd u_coreFrontEnd (
      .gclk       (gclk),
      .grst       (grst),
      .hold       (hold),
      .wbCyc      (wbCyc),
      .wbStb      (wbStb),
      .wbAdr      (wbAdr),
      .wbAck      (wbAck),
      .wbDatI     (wbDatI),
      .msrIe      (msrIe),
      .intReq     (intReq),
      .wrEn       (wrEn),
      .wrAddr     (wrAddr),
      .wrData     (wrData),
      .instWord   (instWord),
      .opcode     (opcode),
      .rd         (rd),
      .ra         (ra),
      .rb         (rb),
      .imm        (imm),
      .simm       (simm),
      .issueValid (issueValid),
      .opA        (opA),
      .opB        (opB),
      .opD        (opD)
   );

   // Program image, every address gives a different word
   // Every tenth word is IMM, return, branch or reads r0 through ra
   function automatic logic [datWidth-1:0] fillWord(input logic [adrWidth-1:0] a);
      logic [datWidth-1:0] w;
      w = (a * 32'h9E3779B1) ^ {a[15:0], ~a[15:0]} ^ (a >> 3);
      case ((a >> 2) % 10)
         0: w[raLsb +: regAddrWidth] = '0;
         2: w[instWidth-1 -: opcWidth] = opcImm;
         5: w[instWidth-1 -: opcWidth] = opcRtd;
         7: w[instWidth-1 -: opcWidth] = opcBccI;
         9: w[instWidth-1 -: opcWidth] = opcBru;
         default: w = w;
      endcase
      // Keep the trap word unique to injection
      if (w == intOp) begin
         w[0] = ~w[0];
      end
      return w;
   endfunction

   // Slave answers after 0 to 3 wait states
   always @(posedge gclk) begin
      #10;
      // Master leaves a one-cycle gap after every ack
      if (ackSeen && wbStb) begin
         flagProblem("wbStb still high in the cycle after an ack");
      end
      ackSeen = 1'b0;
      if (grst || !(wbCyc && wbStb)) begin
         wbAck = 1'b0;
         waitLeft = $unsigned($random(seed)) % 4;
      end else if (waitLeft == 0) begin
         wbAck = 1'b1;
         ackSeen = 1'b1;
         wbDatI = mem[wbAdr[11:2]];
         wordQ.push_back(mem[wbAdr[11:2]]);
         adrQ.push_back(wbAdr);
      end else begin
         waitLeft = waitLeft - 1;
      end
   end

   always @(posedge gclk) begin
      cycleCount++;
      if (cycleCount >= timeoutCycles) begin
         $display("Timeout after %0d cycles in test %s", cycleCount, curTest);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic flagProblem(input string msg);
      errors++;
      $display("ERROR in %s: %s", curTest, msg);
   endtask

   task automatic compareWord(input string what, input logic [instWidth-1:0] expVal,
                              input logic [instWidth-1:0] actVal);
      checks++;
      if (actVal !== expVal) begin
         errors++;
         $display("FAIL %s %s expected %h actual %h", curTest, what, expVal, actVal);
      end
   endtask

   task automatic compareReg(input string what, input logic [regAddrWidth-1:0] expVal,
                             input logic [regAddrWidth-1:0] actVal);
      checks++;
      if (actVal !== expVal) begin
         errors++;
         $display("FAIL %s %s expected %0d actual %0d", curTest, what, expVal, actVal);
      end
   endtask

   // Opcodes whose next word must not be replaced
   function automatic bit needsNextWord(input logic [opcWidth-1:0] opc);
      return (opc == opcImm) || (opc == opcRtd) || (opc == opcBru) || (opc == opcBruI) ||
             (opc == opcBcc) || (opc == opcBccI);
   endfunction

   // Checks one issued word against the scoreboard
   task automatic processIssue();
      logic [instWidth-1:0] expWord;
      logic [instWidth-1:0] expSimm;
      logic [opcWidth-1:0] prevOpc;
      bit isTrap;
      prevOpc = prevWord[instWidth-1 -: opcWidth];
      isTrap = trapAllowed && (instWord === intOp);
      if (!trapAllowed && instWord === intOp) begin
         flagProblem("trap word issued while interrupts were off");
      end
      if (wordQ.size() == 0) begin
         flagProblem("word issued that the bus never delivered");
         return;
      end
      // A dropped word still used its address
      compareWord("address", expAdr, adrQ.pop_front());
      expAdr = expAdr + pcStep;
      if (isTrap) begin
         trapCount++;
         if (needsNextWord(prevOpc)) begin
            flagProblem("trap word issued right after an IMM, return or branch");
         end
         void'(wordQ.pop_front());
         expWord = intOp;
      end else begin
         expWord = wordQ.pop_front();
      end
      compareWord("instWord", expWord, instWord);
      compareWord("opcode", 32'(expWord[instWidth-1 -: opcWidth]), 32'(opcode));
      compareReg("rd", expWord[rdLsb +: regAddrWidth], rd);
      compareReg("ra", expWord[raLsb +: regAddrWidth], ra);
      compareReg("rb", expWord[rbLsb +: regAddrWidth], rb);
      compareWord("imm", 32'(expWord[immWidth-1:0]), 32'(imm));
      // Prefix supplies the upper half
      if (prevOpc == opcImm) begin
         immPairs++;
         expSimm = {prevWord[immWidth-1:0], expWord[immWidth-1:0]};
      end else begin
         expSimm = {{(instWidth - immWidth){expWord[immWidth-1]}}, expWord[immWidth-1:0]};
      end
      compareWord("simm", expSimm, simm);
      if (regsKnown) begin
         compareWord("opA", regModel[expWord[raLsb +: regAddrWidth]], opA);
         compareWord("opB", regModel[expWord[rbLsb +: regAddrWidth]], opB);
         compareWord("opD", regModel[expWord[rdLsb +: regAddrWidth]], opD);
      end
      prevWord = expWord;
      issueCount++;
   endtask

   // One clock, inputs change and outputs are read 10 ns after the edge
   task automatic tick();
      @(posedge gclk);
      #10;
      if (issueValid) begin
         processIssue();
      end
   endtask

   task automatic runIssues(input int count);
      int target;
      target = issueCount + count;
      while (issueCount < target) begin
         tick();
      end
   endtask

   // Raise hold and let the transfer in flight finish
   task automatic holdFetch(output int issued);
      int start;
      start = issueCount;
      hold = 1'b1;
      do begin
         tick();
      end while (wbCyc || issueValid);
      issued = issueCount - start;
   endtask

   task automatic startTest(input string name);
      curTest = name;
      errStart = errors;
   endtask

   task automatic endTest();
      if (errors == errStart) begin
         $display("%-12s ok", curTest);
      end else begin
         testsFailed++;
         $display("%-12s failed with %0d errors", curTest, errors - errStart);
      end
   endtask

   task automatic seqFetchTest();
      startTest("seqFetch");
      runIssues(100);
      endTest();
   endtask

   task automatic fieldImmTest();
      int pairsBefore;
      startTest("fieldImm");
      pairsBefore = immPairs;
      runIssues(100);
      if (immPairs == pairsBefore) begin
         flagProblem("no word following an IMM prefix was issued");
      end
      endTest();
   endtask

   task automatic operandTest();
      int inFlight;
      startTest("operands");
      holdFetch(inFlight);
      // Fill every register, r0 included, with fetch stopped
      for (int r = 0; r < 32; r++) begin
         wrEn = 1'b1;
         wrAddr = regAddrWidth'(r);
         wrData = $random(seed);
         regModel[r] = (r == 0) ? '0 : wrData;
         tick();
      end
      wrEn = 1'b0;
      tick();
      regsKnown = 1'b1;
      hold = 1'b0;
      runIssues(50);
      endTest();
   endtask

   task automatic interruptTest();
      int inFlight;
      startTest("interrupt");
      trapCount = 0;
      trapAllowed = 1'b1;
      msrIe = 1'b1;
      // Park fetch right after an IMM prefix
      // Pending trap has to skip the word that follows it
      do begin
         runIssues(1);
      end while (prevWord[instWidth-1 -: opcWidth] != opcImm);
      holdFetch(inFlight);
      intReq = 1'b1;
      repeat (3) tick();
      intReq = 1'b0;
      hold = 1'b0;
      runIssues(40);
      if (trapCount != 1) begin
         flagProblem($sformatf("expected one trap word, saw %0d", trapCount));
      end
      // Same request with interrupts off must not inject
      trapAllowed = 1'b0;
      msrIe = 1'b0;
      intReq = 1'b1;
      repeat (3) tick();
      intReq = 1'b0;
      runIssues(20);
      endTest();
   endtask

   task automatic holdTest();
      int inFlight;
      int start;
      bit quiet;
      startTest("hold");
      // Raise hold with a transfer on the bus
      do begin
         tick();
      end while (!wbCyc);
      holdFetch(inFlight);
      if (inFlight != 1) begin
         flagProblem($sformatf("%0d words issued after hold, expected one", inFlight));
      end
      start = issueCount;
      quiet = 1'b1;
      repeat (10) begin
         tick();
         if (wbCyc) begin
            quiet = 1'b0;
         end
      end
      if (issueCount != start || !quiet) begin
         flagProblem("fetch carried on while hold was high");
      end
      hold = 1'b0;
      // Address check inside each issue catches a skipped word
      runIssues(50);
      endTest();
   endtask

   initial begin
      hold = 1'b0;
      msrIe = 1'b0;
      intReq = 1'b0;
      wrEn = 1'b0;
      wrAddr = '0;
      wrData = '0;
      wbAck = 1'b0;
      wbDatI = '0;
      expAdr = resetPc;
      prevWord = '0;
      for (int i = 0; i < memWords; i++) begin
         mem[i] = fillWord(adrWidth'(i * 4));
      end
      for (int r = 0; r < 32; r++) begin
         regModel[r] = '0;
      end
      wait (grst === 1'b1);
      wait (grst === 1'b0);
      seqFetchTest();
      fieldImmTest();
      operandTest();
      interruptTest();
      holdTest();
      $display("5 tests, %0d failed, %0d checks, %0d errors", testsFailed, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
hdl/isaPkg.sv
hdl/busPkg.sv
hdl/fetchUnit.sv
hdl/instBuffer.sv
hdl/operandFetch.sv
hdl/coreFrontEnd.sv
tests/clockGen.sv
tests/tbFrontEnd.sv

// ==== Bender.yml ====
package:
  name: core_front_end

sources:
  # Packages first, then the stages and the top level
  - hdl/isaPkg.sv
  - hdl/busPkg.sv
  - hdl/fetchUnit.sv
  - hdl/instBuffer.sv
  - hdl/operandFetch.sv
  - hdl/coreFrontEnd.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/tbFrontEnd.sv
